// ==== files.f ====
verilog/lc4_pkg.sv
verilog/lc4_fetch_pc.sv
verilog/lc4_decode.sv
verilog/lc4_regfile.sv
verilog/lc4_execute.sv
verilog/lc4_branch_control.sv
verilog/lc4_pipeline.sv
+incdir+verification
verification/lc4_pipeline_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the LC4 pipeline testbench with Verilator.
# Exits with status 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=lc4_pipeline_tb
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/1ps \
   --top-module "$TOP" -f files.f -o "$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
   exit 0
else
   echo "Pass line not found in $LOG_FILE"
   exit 1
fi

// ==== verification/lc4_program_table.svh ====
/* Program words and expected commit records, one row per word at
   BOOT_PC plus the row index. Squashed rows must never commit.
   Included inside the testbench module, which supplies NUM_ROWS. */
`ifndef LC4_PROGRAM_TABLE_SVH
`define LC4_PROGRAM_TABLE_SVH

logic [15:0] prog_word    [NUM_ROWS];
logic        row_squashed [NUM_ROWS];
logic        exp_we       [NUM_ROWS];
logic [2:0]  exp_wsel     [NUM_ROWS];
logic [15:0] exp_wdata    [NUM_ROWS];
logic        exp_nzp_we   [NUM_ROWS];
logic [2:0]  exp_nzp      [NUM_ROWS];
int          fill_idx;

function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] imm9);
   return {4'b1001, rd, imm9};
endfunction

function automatic logic [15:0] enc_add(input logic [2:0] rd, input logic [2:0] rs,
                                        input logic [2:0] rt);
   return {4'b0001, rd, rs, 3'b000, rt};
endfunction

function automatic logic [15:0] enc_sub(input logic [2:0] rd, input logic [2:0] rs,
                                        input logic [2:0] rt);
   return {4'b0001, rd, rs, 3'b010, rt};
endfunction

function automatic logic [15:0] enc_add_imm(input logic [2:0] rd, input logic [2:0] rs,
                                            input logic [4:0] imm5);
   return {4'b0001, rd, rs, 1'b1, imm5};
endfunction

function automatic logic [15:0] enc_br(input logic [2:0] nzp, input logic [8:0] imm9);
   return {4'b0000, nzp, imm9};
endfunction

// Every register write also writes NZP from the written value
task automatic put_row(input logic [15:0] word, input logic squashed, input logic we,
                       input logic [2:0] wsel, input logic [15:0] wdata);
   prog_word[fill_idx]    = word;
   row_squashed[fill_idx] = squashed;
   exp_we[fill_idx]       = we;
   exp_wsel[fill_idx]     = wsel;
   exp_wdata[fill_idx]    = wdata;
   exp_nzp_we[fill_idx]   = we;
   exp_nzp[fill_idx]      = sign_class(wdata);
   fill_idx++;
endtask

task automatic build_program_table();
   logic [31:0] draw;
   logic [8:0]  rnd_a;
   logic [8:0]  rnd_b;
   logic [4:0]  rnd_c;
   logic [15:0] r1, r2, r3, r4, r5, r6, r7;
   draw  = $random(rand_seed);
   rnd_a = draw[8:0];
   draw  = $random(rand_seed);
   rnd_b = draw[8:0];
   draw  = $random(rand_seed);
   rnd_c = draw[4:0];
   r1 = {{7{rnd_a[8]}}, rnd_a};
   r2 = {{7{rnd_b[8]}}, rnd_b};
   r3 = r1 + r2;
   r4 = r3 - r2;
   r5 = r4 + {{11{rnd_c[4]}}, rnd_c};
   r6 = r5 + r5;
   r7 = r6 - r2;
   fill_idx = 0;
   put_row(enc_const(3'd1, 9'd5), 1'b0, 1'b1, 3'd1, 16'h0005);
   put_row(enc_const(3'd2, 9'h1fd), 1'b0, 1'b1, 3'd2, 16'hfffd);
   put_row(enc_add(3'd3, 3'd1, 3'd2), 1'b0, 1'b1, 3'd3, 16'h0002);     // W-to-D and W-to-X
   put_row(enc_sub(3'd4, 3'd3, 3'd1), 1'b0, 1'b1, 3'd4, 16'hfffd);
   put_row(enc_add_imm(3'd5, 3'd4, 5'd3), 1'b0, 1'b1, 3'd5, 16'h0000);
   put_row(enc_br(3'b010, 9'd2), 1'b0, 1'b0, 3'd0, 16'h0000);          // Taken, NZP from X
   put_row(enc_const(3'd6, 9'h077), 1'b1, 1'b1, 3'd6, 16'h0077);
   put_row(enc_const(3'd7, 9'h055), 1'b1, 1'b1, 3'd7, 16'h0055);
   put_row(enc_add_imm(3'd6, 3'd5, 5'h1f), 1'b0, 1'b1, 3'd6, 16'hffff);
   put_row(enc_br(3'b001, 9'd2), 1'b0, 1'b0, 3'd0, 16'h0000);          // Not taken
   put_row(16'h0000, 1'b0, 1'b0, 3'd0, 16'h0000);
   // Taken from the NZP register, X and W write no NZP here
   put_row(enc_br(3'b100, 9'd2), 1'b0, 1'b0, 3'd0, 16'h0000);
   put_row(enc_add(3'd1, 3'd1, 3'd1), 1'b1, 1'b1, 3'd1, 16'h000a);
   put_row(enc_sub(3'd2, 3'd2, 3'd2), 1'b1, 1'b1, 3'd2, 16'h0000);
   put_row(enc_const(3'd1, rnd_a), 1'b0, 1'b1, 3'd1, r1);
   put_row(enc_const(3'd2, rnd_b), 1'b0, 1'b1, 3'd2, r2);
   put_row(enc_add(3'd3, 3'd1, 3'd2), 1'b0, 1'b1, 3'd3, r3);
   put_row(enc_sub(3'd4, 3'd3, 3'd2), 1'b0, 1'b1, 3'd4, r4);
   put_row(enc_add_imm(3'd5, 3'd4, rnd_c), 1'b0, 1'b1, 3'd5, r5);
   put_row(enc_const(3'd7, 9'd0), 1'b0, 1'b1, 3'd7, 16'h0000);
   put_row(16'h0000, 1'b0, 1'b0, 3'd0, 16'h0000);
   put_row(enc_br(3'b010, 9'd2), 1'b0, 1'b0, 3'd0, 16'h0000);          // Taken, NZP from W
   put_row(enc_const(3'd5, 9'h1aa), 1'b1, 1'b1, 3'd5, 16'hffaa);
   put_row(enc_add_imm(3'd6, 3'd6, 5'd1), 1'b1, 1'b1, 3'd6, 16'h0000);
   put_row(enc_add(3'd6, 3'd5, 3'd5), 1'b0, 1'b1, 3'd6, r6);
   put_row(enc_sub(3'd7, 3'd6, 3'd2), 1'b0, 1'b1, 3'd7, r7);
   put_row(16'h0000, 1'b0, 1'b0, 3'd0, 16'h0000);
endtask

`endif

// ==== verification/lc4_pipeline_tb.sv ====
/* Testbench for the LC4 subset pipeline. Models the instruction memory
   from the program table and checks each W-stage commit in program order.
   Words outside the table read as NOP. Bubbles in W must carry the flush
   code and write nothing. */
module lc4_pipeline_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          CLK_PERIOD     = 40;
   localparam int          DRIVE_DELAY    = 2;    // After each rising edge
   localparam int          RESET_CYCLES   = 8;
   localparam int          NUM_ROWS       = 27;
   localparam int          TIMEOUT_MARGIN = 30;
   localparam int          TIMEOUT_CYCLES = 4 * NUM_ROWS + TIMEOUT_MARGIN;
   localparam int          SEED           = 32'h1a5a_6ca7;
   localparam logic [15:0] BOOT_PC        = 16'h8200;
   localparam logic [1:0]  VALID_STALL    = 2'd0;
   localparam logic [1:0]  FLUSH_STALL    = 2'd2;

   logic        gwe;
   logic        i_rst_n;
   logic [15:0] o_cur_pc;
   logic [15:0] i_cur_insn;
   logic [1:0]  o_trace_stall;
   logic [15:0] o_trace_pc;
   logic [15:0] o_trace_insn;
   logic        o_trace_regfile_we;
   logic [2:0]  o_trace_wsel;
   logic [15:0] o_trace_wdata;
   logic        o_trace_nzp_we;
   logic [2:0]  o_trace_nzp;
   int          rand_seed = SEED;
   int          cycle_count;

   // N Z P sign class of a written value, N in bit 2
   function automatic logic [2:0] sign_class(input logic [15:0] value);
      if (value[15]) return 3'b100;
      if (value == 16'h0000) return 3'b010;
      return 3'b001;
   endfunction

   `include "lc4_program_table.svh"

   lc4_pipeline lc4_pipeline_i (
      .gwe(gwe), .i_rst_n(i_rst_n), .o_cur_pc(o_cur_pc), .i_cur_insn(i_cur_insn),
      .o_trace_stall(o_trace_stall), .o_trace_pc(o_trace_pc),
      .o_trace_insn(o_trace_insn), .o_trace_regfile_we(o_trace_regfile_we),
      .o_trace_wsel(o_trace_wsel), .o_trace_wdata(o_trace_wdata),
      .o_trace_nzp_we(o_trace_nzp_we), .o_trace_nzp(o_trace_nzp));

   function automatic logic [15:0] fetch_word(input logic [15:0] pc);
      logic [15:0] offset;
      offset = pc - BOOT_PC;
      if (offset < 16'(NUM_ROWS)) return prog_word[offset];
      return 16'h0000;                      // NOP outside the program
   endfunction

   task automatic check_field(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected) begin
         $display("error %s: expected %h, actual %h", name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Next negative edge with a valid instruction in W
   task automatic wait_for_commit();
      @(negedge gwe);
      while (o_trace_stall != VALID_STALL) begin
         check_field("bubble stall", 16'(FLUSH_STALL), 16'(o_trace_stall));
         check_field("bubble regfile_we", 16'h0000, 16'(o_trace_regfile_we));
         check_field("bubble nzp_we", 16'h0000, 16'(o_trace_nzp_we));
         @(negedge gwe);
      end
   endtask

   task automatic check_commit(input int row);
      check_field($sformatf("row %0d pc", row), BOOT_PC + 16'(row), o_trace_pc);
      check_field($sformatf("row %0d insn", row), prog_word[row], o_trace_insn);
      check_field($sformatf("row %0d regfile_we", row), 16'(exp_we[row]),
                  16'(o_trace_regfile_we));
      check_field($sformatf("row %0d nzp_we", row), 16'(exp_nzp_we[row]),
                  16'(o_trace_nzp_we));
      if (exp_we[row]) begin
         check_field($sformatf("row %0d wsel", row), 16'(exp_wsel[row]), 16'(o_trace_wsel));
         check_field($sformatf("row %0d wdata", row), exp_wdata[row], o_trace_wdata);
      end
      if (exp_nzp_we[row]) begin
         check_field($sformatf("row %0d nzp", row), 16'(exp_nzp[row]), 16'(o_trace_nzp));
      end
   endtask

   initial begin
      gwe = 1'b0;
      forever #(CLK_PERIOD / 2) gwe = ~gwe;
   end

   // Instruction memory answers the PC of the current cycle
   initial begin
      forever begin
         @(posedge gwe);
         #DRIVE_DELAY;
         i_cur_insn = fetch_word(o_cur_pc);
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge gwe);
         cycle_count++;
      end
      $display("error timeout: not all commits seen after %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "simulation timed out");
   end

   initial begin
      i_rst_n    = 1'b0;
      i_cur_insn = 16'h0000;
      build_program_table();
      repeat (RESET_CYCLES) @(posedge gwe);
      #DRIVE_DELAY;
      i_rst_n = 1'b1;
      check_field("boot pc", BOOT_PC, o_cur_pc);
      for (int row = 0; row < NUM_ROWS; row++) begin
         if (!row_squashed[row]) begin
            wait_for_commit();
            check_commit(row);
         end
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== verilog/lc4_pipeline.sv ====
/* Four-stage LC4 subset core: F, D, X, W with no back-pressure.
   The instruction at o_cur_pc shows on the trace ports three cycles later.
   A taken branch costs two bubbles. Trace ports reflect the W stage. */
module lc4_pipeline (
   input  logic              gwe,
   input  logic              i_rst_n,
   output lc4_pkg::word_t    o_cur_pc,
   input  lc4_pkg::word_t    i_cur_insn,
   output lc4_pkg::stall_t   o_trace_stall,
   output lc4_pkg::word_t    o_trace_pc,
   output lc4_pkg::word_t    o_trace_insn,
   output logic              o_trace_regfile_we,
   output lc4_pkg::reg_sel_t o_trace_wsel,
   output lc4_pkg::word_t    o_trace_wdata,
   output logic              o_trace_nzp_we,
   output lc4_pkg::nzp_t     o_trace_nzp
);
   import lc4_pkg::*;

   word_t     d_pc, d_imm, d_rs_data, d_rt_data;
   lc4_insn_t d_insn;
   stall_t    d_stall, next_d_stall;
   reg_sel_t  d_rs, d_rt, d_rd;
   logic      d_regfile_we, d_nzp_we, d_is_branch, d_is_sub, d_use_imm, d_taken;

   word_t     x_pc, x_imm, x_rs_data, x_rt_data, x_result;
   lc4_insn_t x_insn;
   stall_t    x_stall;
   reg_sel_t  x_rs, x_rt, x_rd;
   logic      x_regfile_we, x_nzp_we, x_is_branch, x_is_sub, x_use_imm, x_taken;
   nzp_t      x_nzp;

   word_t     w_pc, w_result;
   lc4_insn_t w_insn;
   stall_t    w_stall;
   reg_sel_t  w_rd;
   logic      w_regfile_we, w_nzp_we, w_valid, w_we;
   nzp_t      w_nzp;

   assign w_valid = (w_stall == STALL_NONE);
   assign w_we    = w_regfile_we && w_valid;

   lc4_fetch_pc lc4_fetch_pc_i (
      .gwe(gwe), .i_rst_n(i_rst_n),
      .i_redirect(x_taken), .i_target(x_result), .o_pc(o_cur_pc));

   lc4_decode lc4_decode_i (
      .i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
      .o_regfile_we(d_regfile_we), .o_nzp_we(d_nzp_we), .o_is_branch(d_is_branch),
      .o_is_sub(d_is_sub), .o_use_imm(d_use_imm), .o_imm(d_imm));

   lc4_regfile lc4_regfile_i (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(d_rs), .i_rt(d_rt),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data),
      .i_rd(w_rd), .i_wdata(w_result), .i_we(w_we));

   lc4_branch_control lc4_branch_control_i (
      .gwe(gwe), .i_rst_n(i_rst_n),
      .i_d_nzp_field(d_insn.imm.rd_nzp), .i_d_is_branch(d_is_branch), .i_d_stall(d_stall),
      .i_x_nzp(x_nzp), .i_x_nzp_we(x_nzp_we), .i_x_stall(x_stall), .i_x_taken(x_taken),
      .i_w_nzp(w_nzp), .i_w_nzp_we(w_nzp_we), .i_w_stall(w_stall),
      .o_take_branch(d_taken), .o_next_d_stall(next_d_stall));

   lc4_execute lc4_execute_i (
      .i_pc(x_pc), .i_is_branch(x_is_branch), .i_is_sub(x_is_sub),
      .i_use_imm(x_use_imm), .i_imm(x_imm), .i_rs(x_rs), .i_rt(x_rt),
      .i_rs_data(x_rs_data), .i_rt_data(x_rt_data),
      .i_w_rd(w_rd), .i_w_we(w_we), .i_w_data(w_result),
      .o_result(x_result), .o_nzp(x_nzp));

   // Stall codes and write enables
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         d_stall      <= STALL_FLUSH;
         x_stall      <= STALL_FLUSH;
         w_stall      <= STALL_FLUSH;
         x_regfile_we <= 1'b0;
         x_nzp_we     <= 1'b0;
         x_taken      <= 1'b0;
         w_regfile_we <= 1'b0;
         w_nzp_we     <= 1'b0;
      end else begin
         d_stall      <= next_d_stall;
         x_stall      <= d_stall;
         w_stall      <= x_stall;
         x_regfile_we <= d_regfile_we;
         x_nzp_we     <= d_nzp_we;
         x_taken      <= d_taken;
         w_regfile_we <= x_regfile_we;
         w_nzp_we     <= x_nzp_we;
      end
   end

   always_ff @(posedge gwe) begin
      d_pc        <= o_cur_pc;
      d_insn      <= i_cur_insn;
      x_pc        <= d_pc;
      x_insn      <= d_insn;
      x_rs        <= d_rs;
      x_rt        <= d_rt;
      x_rd        <= d_rd;
      x_is_branch <= d_is_branch;
      x_is_sub    <= d_is_sub;
      x_use_imm   <= d_use_imm;
      x_imm       <= d_imm;
      x_rs_data   <= d_rs_data;
      x_rt_data   <= d_rt_data;
      w_pc        <= x_pc;
      w_insn      <= x_insn;
      w_rd        <= x_rd;
      w_result    <= x_result;
      w_nzp       <= x_nzp;
   end

   assign o_trace_stall      = w_stall;
   assign o_trace_pc         = w_pc;
   assign o_trace_insn       = w_insn;
   assign o_trace_regfile_we = w_we;
   assign o_trace_wsel       = w_rd;
   assign o_trace_wdata      = w_result;
   assign o_trace_nzp_we     = w_nzp_we && w_valid;
   assign o_trace_nzp        = w_nzp;

endmodule

// ==== verilog/lc4_branch_control.sv ====
/* Branch decision in D with NZP forwarding from X, then W, then the
   NZP register. A taken branch squashes the next two fetches. */
module lc4_branch_control (
   input  logic            gwe,
   input  logic            i_rst_n,
   input  lc4_pkg::nzp_t   i_d_nzp_field,
   input  logic            i_d_is_branch,
   input  lc4_pkg::stall_t i_d_stall,
   input  lc4_pkg::nzp_t   i_x_nzp,
   input  logic            i_x_nzp_we,
   input  lc4_pkg::stall_t i_x_stall,
   input  logic            i_x_taken,
   input  lc4_pkg::nzp_t   i_w_nzp,
   input  logic            i_w_nzp_we,
   input  lc4_pkg::stall_t i_w_stall,
   output logic            o_take_branch,
   output lc4_pkg::stall_t o_next_d_stall
);
   import lc4_pkg::*;

   nzp_t nzp_q;
   nzp_t cur_nzp;
   logic x_fwd;
   logic w_commit;

   assign x_fwd    = i_x_nzp_we && i_x_stall == STALL_NONE;
   assign w_commit = i_w_nzp_we && i_w_stall == STALL_NONE;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         nzp_q <= '0;
      end else if (w_commit) begin
         nzp_q <= i_w_nzp;
      end
   end

   assign cur_nzp = x_fwd    ? i_x_nzp :
                    w_commit ? i_w_nzp :
                               nzp_q;

   assign o_take_branch = i_d_is_branch && i_d_stall == STALL_NONE &&
                          (|(i_d_nzp_field & cur_nzp));

   // Squash the fetch behind the branch in D and the one behind it in X
   assign o_next_d_stall = (o_take_branch || i_x_taken) ? STALL_FLUSH : STALL_NONE;

endmodule

// ==== verilog/lc4_execute.sv ====
/* Combinational X stage with W-to-X operand bypass and one adder path.
   use_imm with is_sub means CONST: the rs operand is replaced by zero.
   For a branch the result is the target PC+1+imm. */
module lc4_execute (
   input  lc4_pkg::word_t    i_pc,
   input  logic              i_is_branch,
   input  logic              i_is_sub,
   input  logic              i_use_imm,
   input  lc4_pkg::word_t    i_imm,
   input  lc4_pkg::reg_sel_t i_rs,
   input  lc4_pkg::reg_sel_t i_rt,
   input  lc4_pkg::word_t    i_rs_data,
   input  lc4_pkg::word_t    i_rt_data,
   input  lc4_pkg::reg_sel_t i_w_rd,
   input  logic              i_w_we,
   input  lc4_pkg::word_t    i_w_data,
   output lc4_pkg::word_t    o_result,
   output lc4_pkg::nzp_t     o_nzp
);
   import lc4_pkg::*;

   word_t rs_val;
   word_t rt_val;

   assign rs_val = (i_w_we && i_w_rd == i_rs) ? i_w_data : i_rs_data;
   assign rt_val = (i_w_we && i_w_rd == i_rt) ? i_w_data : i_rt_data;

   always_comb begin
      if (i_is_branch) begin
         o_result = i_pc + word_t'(1) + i_imm;
      end else if (i_use_imm) begin
         o_result = (i_is_sub ? '0 : rs_val) + i_imm;
      end else if (i_is_sub) begin
         o_result = rs_val - rt_val;
      end else begin
         o_result = rs_val + rt_val;
      end
   end

   // Sign class of the result
   assign o_nzp = o_result[WORD_W-1] ? 3'b100 :
                  (o_result == '0)   ? 3'b010 :
                                       3'b001;

endmodule

// ==== verilog/lc4_regfile.sv ====
/* Eight 16-bit registers, two combinational read ports, one write port.
   A read of the register written this cycle returns the write data,
   which gives the W-to-D bypass. */
module lc4_regfile (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::reg_sel_t i_rs,
   input  lc4_pkg::reg_sel_t i_rt,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data,
   input  lc4_pkg::reg_sel_t i_rd,
   input  lc4_pkg::word_t    i_wdata,
   input  logic              i_we       // Already qualified by W stall code
);
   import lc4_pkg::*;

   word_t regs [2**REG_SEL_W];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         regs <= '{default: '0};
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Write-through
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// ==== verilog/lc4_decode.sv ====
/* Combinational D-stage decoder for BR, ADD/SUB, ADD imm5 and CONST.
   CONST leaves with use_imm and is_sub both set, which execute reads
   as immediate pass-through. Unknown opcodes write nothing. */
module lc4_decode (
   input  lc4_pkg::lc4_insn_t i_insn,
   output lc4_pkg::reg_sel_t  o_rs,
   output lc4_pkg::reg_sel_t  o_rt,
   output lc4_pkg::reg_sel_t  o_rd,
   output logic               o_regfile_we,
   output logic               o_nzp_we,
   output logic               o_is_branch,
   output logic               o_is_sub,
   output logic               o_use_imm,
   output lc4_pkg::word_t     o_imm
);
   import lc4_pkg::*;

   word_t imm5_sext;
   word_t imm9_sext;

   assign imm5_sext = {{(WORD_W-5){i_insn.arith.low.imm5[4]}}, i_insn.arith.low.imm5};
   assign imm9_sext = {{(WORD_W-9){i_insn.imm.imm9[8]}}, i_insn.imm.imm9};

   always_comb begin
      o_rs         = i_insn.arith.rs;
      o_rt         = i_insn.arith.low.rr.rt;
      o_rd         = i_insn.arith.rd;
      o_regfile_we = 1'b0;
      o_nzp_we     = 1'b0;
      o_is_branch  = 1'b0;
      o_is_sub     = 1'b0;
      o_use_imm    = 1'b0;
      o_imm        = imm5_sext;
      case (i_insn.arith.opcode)
         OP_ARITH: begin
            if (i_insn.arith.imm_flag) begin
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
               o_use_imm    = 1'b1;
            end else if ({1'b0, i_insn.arith.low.rr.subop_lo} == SUBOP_ADD ||
                         {1'b0, i_insn.arith.low.rr.subop_lo} == SUBOP_SUB) begin
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
               o_is_sub     = ({1'b0, i_insn.arith.low.rr.subop_lo} == SUBOP_SUB);
            end
         end
         OP_CONST: begin
            o_rd         = i_insn.imm.rd_nzp;
            o_rs         = '0;            // R0, its value is dropped in X
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
            o_is_sub     = 1'b1;
            o_use_imm    = 1'b1;
            o_imm        = imm9_sext;
         end
         OP_BR: begin
            o_is_branch = 1'b1;             // NOP too, its mask is zero
            o_imm       = imm9_sext;
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== verilog/lc4_fetch_pc.sv ====
/* Program counter for the F stage. No hold input: the pipeline never
   stalls, so the PC advances or redirects on every edge. */
module lc4_fetch_pc (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  logic           i_redirect,  // Taken branch now in X
   input  lc4_pkg::word_t i_target,
   output lc4_pkg::word_t o_pc
);
   import lc4_pkg::*;

   word_t pc_inc;

   assign pc_inc = o_pc + word_t'(1);

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         o_pc <= RESET_PC;
      end else if (i_redirect) begin
         o_pc <= i_target;
      end else begin
         o_pc <= pc_inc;
      end
   end

endmodule

// ==== verilog/lc4_pkg.sv ====
/* Shared widths, encodings and types for the LC4 subset core.
   Only BR, ADD/SUB (register and imm5) and CONST are decoded.
   Stall codes 1 and 3 are unused in this core. */
package lc4_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NZP_W     = 3;   // Bit 2 N, bit 1 Z, bit 0 P
   localparam int STALL_W   = 2;
   localparam int OPCODE_W  = 4;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;
   typedef logic [NZP_W-1:0]     nzp_t;
   typedef logic [STALL_W-1:0]   stall_t;
   typedef logic [OPCODE_W-1:0]  opcode_t;

   localparam stall_t STALL_NONE  = 2'd0;  // Valid instruction
   localparam stall_t STALL_FLUSH = 2'd2;  // Bubble from reset or squash

   localparam word_t RESET_PC = 16'h8200;

   localparam opcode_t OP_BR    = 4'b0000;
   localparam opcode_t OP_ARITH = 4'b0001;
   localparam opcode_t OP_CONST = 4'b1001;

   // Full sub-op is {imm flag, bits 4:3}
   localparam logic [2:0] SUBOP_ADD = 3'b000;
   localparam logic [2:0] SUBOP_SUB = 3'b010;

   typedef struct packed {
      logic [1:0] subop_lo;
      reg_sel_t   rt;
   } rr_low_t;

   // Low five bits of an arithmetic word, register or immediate form
   typedef union packed {
      rr_low_t    rr;
      logic [4:0] imm5;
   } arith_low_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_sel_t   rd;
      reg_sel_t   rs;
      logic       imm_flag;
      arith_low_t low;
   } arith_view_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_sel_t   rd_nzp;   // Destination for CONST, condition mask for BR
      logic [8:0] imm9;
   } imm_view_t;

   typedef union packed {
      arith_view_t arith;
      imm_view_t   imm;
   } lc4_insn_t;

endpackage
